// ==== common/trap_pkg.sv ====
// Trap unit package: data types, machine CSR addresses and fixed CSR field values.
`default_nettype none

package trap_pkg;

    // Data word on the CSR port.
    typedef logic [31:0] word_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Instruction address, halfword aligned.
    typedef logic [31:1] pc_t;
    // Trap vector base, word aligned.
    typedef logic [31:2] tvec_t;
    // Interrupt or trap number.
    typedef logic [4:0] cause_t;
    // Synchronous trap cause from the core.
    typedef logic [3:0] trap_cause_t;
    // External interrupt lines 16 to 31.
    typedef logic [31:16] ext_irq_t;

    // Machine CSR address map.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    localparam csr_addr_t CSR_MVENDORID  = 12'hF11;
    localparam csr_addr_t CSR_MARCHID    = 12'hF12;
    localparam csr_addr_t CSR_MIMPID     = 12'hF13;
    localparam csr_addr_t CSR_MHARTID    = 12'hF14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hF15;

    // Registered architecture ID.
    localparam word_t MARCH_ID = 32'd37;
    // Version 2.0.0, major in bits 15 to 8.
    localparam word_t MIMPID_VALUE = 32'h0000_0200;

    // Machine timer interrupt number.
    localparam cause_t TIMER_IRQ_NO = 5'd7;
    // Edges with MIE set before interrupts are taken.
    localparam int MIE_DELAY = 2;

    // mstatus field positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    // Only M-mode exists, so MPP always reads 3.
    localparam logic [1:0] MSTATUS_MPP_VALUE = 2'd3;

endpackage

`default_nettype wire

// ==== hw/irq_arbiter.sv ====
// Interrupt arbiter: pending latch, enable mask, priority select and MIE delay.
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire trap_pkg::ext_irq_t irq,
    input  wire logic               timer_irq,
    input  wire trap_pkg::word_t    mie_mask,
    input  wire logic               status_mie,
    output trap_pkg::word_t         pending,
    output logic                    irq_req,
    output trap_pkg::cause_t        irq_cause
);

    // Next pending vector, before the register.
    trap_pkg::word_t pending_next;
    // Pending lines that are also enabled.
    trap_pkg::word_t masked;
    // MIE value seen at the last few edges.
    logic [trap_pkg::MIE_DELAY-1:0] mie_hist;

    // External lines on top, timer at bit 7.
    always_comb begin
        pending_next = '0;
        pending_next[31:16] = irq;
        pending_next[trap_pkg::TIMER_IRQ_NO] = timer_irq;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= '0;
            mie_hist <= '0;
        end else begin
            pending  <= pending_next;
            // Oldest sample drops off the top.
            mie_hist <= {mie_hist[trap_pkg::MIE_DELAY-2:0], status_mie};
        end
    end

    assign masked = pending & mie_mask;

    // Lowest number wins, so scan downward and let the last hit stand.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    // Clearing MIE blocks at once through the live term.
    assign irq_req = (masked != '0) && (&mie_hist) && status_mie;

endmodule

`default_nettype wire

// ==== csr/csr_file.sv ====
// Machine CSR file: storage, read decode, and trap, write and return updates.
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter trap_pkg::word_t HART_ID = '0,
    parameter bit HAS_M = 1'b1,
    parameter bit HAS_A = 1'b1,
    parameter bit HAS_C = 1'b1
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire trap_pkg::csr_addr_t csr_addr,
    input  wire logic                csr_we,
    input  wire trap_pkg::word_t     csr_wdata,
    input  wire trap_pkg::word_t     pending,
    input  wire logic                exc_taken,
    input  wire logic                exc_irq,
    input  wire trap_pkg::cause_t    exc_cause,
    input  wire trap_pkg::pc_t       exc_epc,
    input  wire logic                mret,
    output trap_pkg::word_t          csr_rdata,
    output logic                     csr_exists,
    output logic                     csr_rdonly,
    output trap_pkg::word_t          mie_mask,
    output logic                     status_mie,
    output trap_pkg::tvec_t          mtvec,
    output trap_pkg::pc_t            mepc
);

    // Previous interrupt enable.
    logic status_mpie;
    // Per-interrupt enables.
    trap_pkg::word_t mie;
    trap_pkg::word_t mscratch;
    // mcause split into flag and number.
    logic mcause_int;
    trap_pkg::cause_t mcause_no;

    // Assembled read values.
    trap_pkg::word_t mstatus_val;
    trap_pkg::word_t misa_val;
    trap_pkg::word_t mcause_val;
    trap_pkg::word_t mip_val;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[trap_pkg::MSTATUS_MIE_BIT]  = status_mie;
        mstatus_val[trap_pkg::MSTATUS_MPIE_BIT] = status_mpie;
        mstatus_val[12:11] = trap_pkg::MSTATUS_MPP_VALUE;
    end

    // Extension letters A, C, I, M and MXL of 32 bits.
    always_comb begin
        misa_val = '0;
        misa_val[0]     = HAS_A;
        misa_val[2]     = HAS_C;
        misa_val[8]     = 1'b1;
        misa_val[12]    = HAS_M;
        misa_val[31:30] = 2'b01;
    end

    assign mcause_val = {mcause_int, 26'd0, mcause_no};
    // Only enabled lines show as pending.
    assign mip_val = pending & mie;

    // Read decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            trap_pkg::CSR_MSTATUS:  csr_rdata = mstatus_val;
            // Fixed by the extension parameters.
            trap_pkg::CSR_MISA: begin
                csr_rdonly = 1'b1;
                csr_rdata  = misa_val;
            end
            trap_pkg::CSR_MEDELEG:  csr_rdata = '0;
            trap_pkg::CSR_MIDELEG:  csr_rdata = '0;
            trap_pkg::CSR_MIE:      csr_rdata = mie;
            trap_pkg::CSR_MTVEC:    csr_rdata = {mtvec, 2'b00};
            trap_pkg::CSR_MSTATUSH: csr_rdata = '0;
            trap_pkg::CSR_MIP:      csr_rdata = mip_val;
            trap_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            trap_pkg::CSR_MEPC:     csr_rdata = {mepc, 1'b0};
            trap_pkg::CSR_MCAUSE:   csr_rdata = mcause_val;
            trap_pkg::CSR_MTVAL:    csr_rdata = '0;
            // Identity registers.
            trap_pkg::CSR_MVENDORID: begin
                csr_rdonly = 1'b1;
            end
            trap_pkg::CSR_MARCHID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::MARCH_ID;
            end
            trap_pkg::CSR_MIMPID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::MIMPID_VALUE;
            end
            trap_pkg::CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = HART_ID;
            end
            trap_pkg::CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    // Exception beats write, write beats mret.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_no   <= '0;
        end else if (exc_taken) begin
            // Stack the enable and record the cause.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mepc        <= exc_epc;
            mcause_int  <= exc_irq;
            mcause_no   <= exc_cause;
        end else if (csr_we) begin
            case (csr_addr)
                trap_pkg::CSR_MSTATUS: begin
                    status_mie  <= csr_wdata[trap_pkg::MSTATUS_MIE_BIT];
                    status_mpie <= csr_wdata[trap_pkg::MSTATUS_MPIE_BIT];
                end
                trap_pkg::CSR_MIE:      mie <= csr_wdata;
                trap_pkg::CSR_MTVEC:    mtvec <= csr_wdata[31:2];
                trap_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                trap_pkg::CSR_MEPC:     mepc <= csr_wdata[31:1];
                trap_pkg::CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                // Read-only and zero CSRs drop the write.
                default: ;
            endcase
        end else if (mret) begin
            // Unstack the enable.
            status_mie <= status_mpie;
        end
    end

    assign mie_mask = mie;

endmodule

`default_nettype wire

// ==== hw/trap_dispatch.sv ====
// Exception dispatch: merges the interrupt request and the trap strobe into one event.
`timescale 1ns/1ps
`default_nettype none

module trap_dispatch (
    input  wire logic                  irq_req,
    input  wire trap_pkg::cause_t      irq_cause,
    input  wire logic                  retire_valid,
    input  wire logic                  trap_valid,
    input  wire trap_pkg::trap_cause_t trap_cause,
    input  wire trap_pkg::pc_t         wb_pc,
    output logic                       exc_taken,
    output logic                       exc_irq,
    output trap_pkg::cause_t           exc_cause,
    output trap_pkg::pc_t              exc_epc
);

    // Interrupts only land on a retiring instruction.
    logic irq_take;

    assign irq_take = irq_req && retire_valid;

    always_comb begin
        if (irq_take) begin
            // Interrupt wins over a trap in the same cycle.
            exc_taken = 1'b1;
            exc_irq   = 1'b1;
            exc_cause = irq_cause;
        end else if (trap_valid) begin
            exc_taken = 1'b1;
            exc_irq   = 1'b0;
            exc_cause = trap_pkg::cause_t'(trap_cause);
        end else begin
            // Nothing to dispatch.
            exc_taken = 1'b0;
            exc_irq   = 1'b0;
            exc_cause = '0;
        end
    end

    // Return address is word aligned.
    assign exc_epc = {wb_pc[31:2], 1'b0};

endmodule

`default_nettype wire

// ==== hw/trap_unit.sv ====
// Trap unit top level: interrupt arbiter, machine CSR file and exception dispatch.
`timescale 1ns/1ps
`default_nettype none

module trap_unit #(
    parameter trap_pkg::word_t HART_ID = '0,
    parameter bit HAS_M = 1'b1,
    parameter bit HAS_A = 1'b1,
    parameter bit HAS_C = 1'b1
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire trap_pkg::ext_irq_t    irq,
    input  wire logic                  timer_irq,
    input  wire trap_pkg::csr_addr_t   csr_addr,
    input  wire logic                  csr_we,
    input  wire trap_pkg::word_t       csr_wdata,
    input  wire logic                  retire_valid,
    input  wire logic                  trap_valid,
    input  wire trap_pkg::trap_cause_t trap_cause,
    input  wire trap_pkg::pc_t         wb_pc,
    input  wire logic                  mret,
    output trap_pkg::word_t            csr_rdata,
    output logic                       csr_exists,
    output logic                       csr_rdonly,
    output logic                       exc_taken,
    output logic                       exc_irq,
    output trap_pkg::tvec_t            exc_tvec,
    output trap_pkg::pc_t              ret_epc,
    output logic                       status_mie
);

    // Enable mask from mie.
    trap_pkg::word_t mie_mask;
    // Latched interrupt lines.
    trap_pkg::word_t pending;
    // Arbiter result.
    logic irq_req;
    trap_pkg::cause_t irq_cause;
    // Exception event into the CSRs.
    trap_pkg::cause_t exc_cause;
    trap_pkg::pc_t exc_epc;

    irq_arbiter u_irq_arbiter (
        .clk        (clk),
        .rst        (rst),
        .irq        (irq),
        .timer_irq  (timer_irq),
        .mie_mask   (mie_mask),
        .status_mie (status_mie),
        .pending    (pending),
        .irq_req    (irq_req),
        .irq_cause  (irq_cause)
    );

    trap_dispatch u_trap_dispatch (
        .irq_req      (irq_req),
        .irq_cause    (irq_cause),
        .retire_valid (retire_valid),
        .trap_valid   (trap_valid),
        .trap_cause   (trap_cause),
        .wb_pc        (wb_pc),
        .exc_taken    (exc_taken),
        .exc_irq      (exc_irq),
        .exc_cause    (exc_cause),
        .exc_epc      (exc_epc)
    );

    // mtvec and mepc leave directly as vector and return address.
    csr_file #(
        .HART_ID (HART_ID),
        .HAS_M   (HAS_M),
        .HAS_A   (HAS_A),
        .HAS_C   (HAS_C)
    ) u_csr_file (
        .clk        (clk),
        .rst        (rst),
        .csr_addr   (csr_addr),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata),
        .pending    (pending),
        .exc_taken  (exc_taken),
        .exc_irq    (exc_irq),
        .exc_cause  (exc_cause),
        .exc_epc    (exc_epc),
        .mret       (mret),
        .csr_rdata  (csr_rdata),
        .csr_exists (csr_exists),
        .csr_rdonly (csr_rdonly),
        .mie_mask   (mie_mask),
        .status_mie (status_mie),
        .mtvec      (exc_tvec),
        .mepc       (ret_epc)
    );

endmodule

`default_nettype wire

// ==== bench/trap_unit_properties.sv ====
// Bound assertions on the trap unit exception and interrupt-enable outputs.
`timescale 1ns/1ps
`default_nettype none

module trap_unit_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic exc_taken,
    input wire logic exc_irq,
    input wire logic status_mie
);

    // An interrupt is always an exception.
    irq_is_exc: assert property (@(posedge clk) disable iff (rst) exc_irq |-> exc_taken)
        else $error("exc_irq high without exc_taken");

    // Taking an exception clears MIE at the next edge.
    exc_clears_mie: assert property (@(posedge clk) disable iff (rst) exc_taken |=> !status_mie)
        else $error("status_mie still set after an exception");

    // Nothing is dispatched in reset.
    quiet_in_reset: assert property (@(posedge clk) rst |-> !exc_taken)
        else $error("exc_taken high during reset");

endmodule

bind trap_unit trap_unit_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .exc_taken  (exc_taken),
    .exc_irq    (exc_irq),
    .status_mie (status_mie)
);

`default_nettype wire

// ==== bench/trap_unit_tb.sv ====
// Trap unit testbench: clock, reset, LCG stimulus, reference model, compare tasks and report.
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb;

    localparam int N_ITER = 16;
    // Reset and reset test, then per iteration csr 5, trap 6, irq 9, delay 7 and return 4.
    localparam int CYCLES = 5 + 5 + N_ITER * (5 + 6 + 9 + 7 + 4);
    localparam int TIMEOUT_NS = CYCLES * 4 + 100;

    logic clk;
    logic rst;
    trap_pkg::ext_irq_t irq;
    logic timer_irq;
    trap_pkg::csr_addr_t csr_addr;
    logic csr_we;
    trap_pkg::word_t csr_wdata;
    logic retire_valid;
    logic trap_valid;
    trap_pkg::trap_cause_t trap_cause;
    trap_pkg::pc_t wb_pc;
    logic mret;
    trap_pkg::word_t csr_rdata;
    logic csr_exists;
    logic csr_rdonly;
    logic exc_taken;
    logic exc_irq;
    trap_pkg::tvec_t exc_tvec;
    trap_pkg::pc_t ret_epc;
    logic status_mie;

    // Reference model state.
    logic m_mie;
    logic m_mpie;
    trap_pkg::word_t m_ie;
    trap_pkg::tvec_t m_mtvec;
    trap_pkg::word_t m_scratch;
    trap_pkg::pc_t m_mepc;
    trap_pkg::word_t m_cause;
    trap_pkg::word_t m_pend;
    logic [trap_pkg::MIE_DELAY-1:0] m_hist;

    trap_pkg::word_t lcg_state;
    int errors;
    int tests;
    int test_errs;
    string cur_test;

    trap_pkg::csr_addr_t wr_addrs [6] = '{trap_pkg::CSR_MSTATUS, trap_pkg::CSR_MIE,
        trap_pkg::CSR_MTVEC, trap_pkg::CSR_MSCRATCH, trap_pkg::CSR_MEPC, trap_pkg::CSR_MCAUSE};
    trap_pkg::csr_addr_t ro_addrs [5] = '{trap_pkg::CSR_MISA, trap_pkg::CSR_MVENDORID,
        trap_pkg::CSR_MARCHID, trap_pkg::CSR_MIMPID, trap_pkg::CSR_MHARTID};

    trap_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Upper bits folded down since the LCG low bits are weak.
    function automatic trap_pkg::word_t lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // Expected read data per CSR address.
    function automatic trap_pkg::word_t exp_read(trap_pkg::csr_addr_t a);
        case (a)
            trap_pkg::CSR_MSTATUS:  return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
            // MXL 1 with A, C, I and M.
            trap_pkg::CSR_MISA:     return 32'h4000_1105;
            trap_pkg::CSR_MIE:      return m_ie;
            trap_pkg::CSR_MTVEC:    return {m_mtvec, 2'b00};
            trap_pkg::CSR_MIP:      return m_pend & m_ie;
            trap_pkg::CSR_MSCRATCH: return m_scratch;
            trap_pkg::CSR_MEPC:     return {m_mepc, 1'b0};
            trap_pkg::CSR_MCAUSE:   return m_cause;
            trap_pkg::CSR_MARCHID:  return 32'd37;
            trap_pkg::CSR_MIMPID:   return trap_pkg::MIMPID_VALUE;
            // Hart 0 by default.
            trap_pkg::CSR_MHARTID:  return 32'd0;
            default:                return 32'd0;
        endcase
    endfunction

    function automatic trap_pkg::cause_t lowest(trap_pkg::word_t v);
        trap_pkg::cause_t n;
        logic found;
        n = '0;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (v[i] && !found) begin
                n = trap_pkg::cause_t'(i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    task automatic check_word(string what, trap_pkg::word_t exp, trap_pkg::word_t act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_tvec(string what, trap_pkg::tvec_t exp, trap_pkg::tvec_t act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_pc(string what, trap_pkg::pc_t exp, trap_pkg::pc_t act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // Checks outputs, steps the model one edge, then clears strobes.
    task automatic tick();
        logic take_irq;
        logic taken;
        logic old_mie;
        take_irq = ((m_pend & m_ie) != '0) && (&m_hist) && m_mie && retire_valid;
        taken = take_irq || trap_valid;
        old_mie = m_mie;
        check_bit("exc_taken", taken, exc_taken);
        check_bit("exc_irq", take_irq, exc_irq);
        check_tvec("exc_tvec", m_mtvec, exc_tvec);
        check_pc("ret_epc", m_mepc, ret_epc);
        check_bit("status_mie", m_mie, status_mie);
        // Exception first, then write, then mret.
        if (taken) begin
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mepc = wb_pc & ~trap_pkg::pc_t'(1);
            m_cause = take_irq ? {1'b1, 26'd0, lowest(m_pend & m_ie)} : {28'd0, trap_cause};
        end else if (csr_we) begin
            case (csr_addr)
                trap_pkg::CSR_MSTATUS: begin
                    m_mie = csr_wdata[3];
                    m_mpie = csr_wdata[7];
                end
                trap_pkg::CSR_MIE:      m_ie = csr_wdata;
                trap_pkg::CSR_MTVEC:    m_mtvec = csr_wdata[31:2];
                trap_pkg::CSR_MSCRATCH: m_scratch = csr_wdata;
                trap_pkg::CSR_MEPC:     m_mepc = csr_wdata[31:1];
                trap_pkg::CSR_MCAUSE:   m_cause = csr_wdata & 32'h8000_001F;
                default: ;
            endcase
        end else if (mret) begin
            m_mie = m_mpie;
        end
        m_hist = {m_hist[trap_pkg::MIE_DELAY-2:0], old_mie};
        m_pend = {irq, 8'd0, timer_irq, 7'd0};
        @(posedge clk);
        #1;
        csr_we = 1'b0;
        trap_valid = 1'b0;
        retire_valid = 1'b0;
        mret = 1'b0;
    endtask

    task automatic idle();
        tick();
        #1;
    endtask

    task automatic write_csr(trap_pkg::csr_addr_t a, trap_pkg::word_t d);
        tick();
        csr_addr = a;
        csr_we = 1'b1;
        csr_wdata = d;
        #1;
    endtask

    task automatic read_csr(trap_pkg::csr_addr_t a, string what);
        tick();
        csr_addr = a;
        #1;
        check_word(what, exp_read(a), csr_rdata);
    endtask

    task automatic set_lines(trap_pkg::ext_irq_t lines, logic timer);
        tick();
        irq = lines;
        timer_irq = timer;
        #1;
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errs)
            $display("%s: ok", cur_test);
        else
            $display("%s: %0d errors", cur_test, errors - test_errs);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        trap_pkg::word_t r;
        logic [2:0] sel;
        logic saved;
        rst = 1'b1;
        irq = '0;
        timer_irq = 1'b0;
        csr_addr = '0;
        csr_we = 1'b0;
        csr_wdata = '0;
        retire_valid = 1'b0;
        trap_valid = 1'b0;
        trap_cause = '0;
        wb_pc = '0;
        mret = 1'b0;
        lcg_state = 32'd75;
        errors = 0;
        tests = 0;
        // Model starts in the reset state.
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_ie = '0;
        m_mtvec = '0;
        m_scratch = '0;
        m_mepc = '0;
        m_cause = '0;
        m_pend = '0;
        m_hist = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;

        begin_test("reset");
        read_csr(trap_pkg::CSR_MSTATUS, "mstatus");
        check_word("mstatus mpp", 32'h0000_1800, csr_rdata);
        read_csr(trap_pkg::CSR_MIE, "mie");
        read_csr(trap_pkg::CSR_MTVEC, "mtvec");
        read_csr(trap_pkg::CSR_MEPC, "mepc");
        read_csr(trap_pkg::CSR_MCAUSE, "mcause");
        end_test();

        begin_test("csr_access");
        repeat (N_ITER) begin
            r = lcg();
            sel = 3'(r % 32'd6);
            write_csr(wr_addrs[sel], lcg());
            read_csr(wr_addrs[sel], "writable readback");
            check_bit("writable exists", 1'b1, csr_exists);
            check_bit("writable rdonly", 1'b0, csr_rdonly);
            r = lcg();
            sel = 3'(r % 32'd5);
            write_csr(ro_addrs[sel], lcg());
            read_csr(ro_addrs[sel], "read-only value");
            check_bit("rdonly", 1'b1, csr_rdonly);
            // 0x8xx holds no machine CSR.
            r = lcg();
            read_csr({4'h8, r[7:0]}, "unknown data");
            check_bit("unknown exists", 1'b0, csr_exists);
        end
        end_test();

        begin_test("trap");
        repeat (N_ITER) begin
            write_csr(trap_pkg::CSR_MTVEC, lcg());
            r = lcg() & 32'h88;
            saved = r[3];
            write_csr(trap_pkg::CSR_MSTATUS, r);
            tick();
            r = lcg();
            trap_valid = 1'b1;
            retire_valid = r[0];
            trap_cause = r[5:2];
            wb_pc = r[31:1];
            #1;
            check_bit("trap taken", 1'b1, exc_taken);
            check_bit("trap irq", 1'b0, exc_irq);
            check_tvec("trap tvec", m_mtvec, exc_tvec);
            read_csr(trap_pkg::CSR_MCAUSE, "mcause");
            read_csr(trap_pkg::CSR_MEPC, "mepc");
            read_csr(trap_pkg::CSR_MSTATUS, "mstatus");
            check_bit("mpie", saved, csr_rdata[7]);
            check_bit("mie cleared", 1'b0, csr_rdata[3]);
        end
        end_test();

        begin_test("irq_priority");
        repeat (N_ITER) begin
            write_csr(trap_pkg::CSR_MIE, lcg() | 32'h8000_0000);
            r = lcg();
            set_lines(r[31:16] | 16'h8000, r[9]);
            write_csr(trap_pkg::CSR_MSTATUS, 32'h8);
            repeat (trap_pkg::MIE_DELAY) idle();
            tick();
            r = lcg();
            retire_valid = 1'b1;
            trap_valid = r[0];
            trap_cause = r[5:2];
            wb_pc = r[31:1];
            #1;
            check_bit("irq wins", 1'b1, exc_irq);
            read_csr(trap_pkg::CSR_MCAUSE, "irq mcause");
            read_csr(trap_pkg::CSR_MIP, "mip");
            set_lines('0, 1'b0);
        end
        end_test();

        begin_test("enable_delay");
        repeat (N_ITER) begin
            write_csr(trap_pkg::CSR_MIE, lcg() | 32'h8000_0000);
            r = lcg();
            set_lines(r[31:16] | 16'h8000, r[9]);
            write_csr(trap_pkg::CSR_MSTATUS, 32'h8);
            // Only the last cycle may take the interrupt.
            for (int k = 0; k <= trap_pkg::MIE_DELAY; k++) begin
                tick();
                retire_valid = 1'b1;
                #1;
                check_bit("delayed irq", k == trap_pkg::MIE_DELAY, exc_irq);
            end
            set_lines('0, 1'b0);
        end
        end_test();

        begin_test("mret");
        repeat (N_ITER) begin
            r = lcg() & 32'h88;
            saved = r[7];
            write_csr(trap_pkg::CSR_MSTATUS, r);
            write_csr(trap_pkg::CSR_MEPC, lcg());
            tick();
            mret = 1'b1;
            #1;
            read_csr(trap_pkg::CSR_MSTATUS, "mstatus after mret");
            check_bit("mie restored", saved, status_mie);
        end
        end_test();

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/trap_pkg.sv
hw/irq_arbiter.sv
csr/csr_file.sv
hw/trap_dispatch.sv
hw/trap_unit.sv
bench/trap_unit_properties.sv
bench/trap_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= trap_unit_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# A crashed or aborted run counts as a failure too.
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
